// File: t4io.f
+incdir+.
t4io_bus_pkg.sv
t4io_dev_pkg.sv
t4io_port_decode.sv
t4io_hires.sv
t4io_orch90.sv
t4io_int_ctrl.sv
t4io_top.sv
tb_t4io.sv

// File: tb_t4io.sv
`include "t4io_defines.svh"

module tb_t4io;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int max_cycles = 4000;   // tests take about 1300 cycles

   logic                  z80_clk;
   logic                  z80_rst_n;
   t4io_bus_pkg::wb_req_t wb;
   logic                  rtc_tick;
   logic                  ack;
   logic [7:0]            dat_o;
   logic                  int_n;
   logic                  orch_l;
   logic                  orch_r;
   logic                  hires_graphics;

   integer     seed;
   int         cycles;
   logic [7:0] x_last;                 // hi-res state left by the hi-res tests
   logic [7:0] y_last;
   logic [7:0] opt_last;

   t4io_top dut (
      .z80_clk        (z80_clk),
      .z80_rst_n      (z80_rst_n),
      .wb             (wb),
      .rtc_tick       (rtc_tick),
      .ack            (ack),
      .dat_o          (dat_o),
      .int_n          (int_n),
      .orch_l         (orch_l),
      .orch_r         (orch_r),
      .hires_graphics (hires_graphics)
   );

   always #4 z80_clk = ~z80_clk;       // 8 ns period

   always @(posedge z80_clk)
   begin
      cycles++;
      if (cycles >= max_cycles)
      begin
         $display("timeout: the tests did not finish within %0d cycles", max_cycles);
         $display("Test failed");
         $fatal(1, "run stopped");
      end
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // one wishbone transfer, called and returning on a falling edge
   task automatic bus_xfer(input logic [7:0] adr, input logic we, input logic [7:0] wdat,
                           output logic [7:0] rdat);
      int n;
      wb.adr = adr;
      wb.dat = wdat;
      wb.we  = we;
      wb.cyc = 1'b1;
      wb.stb = 1'b1;
      n = 1;
      @(negedge z80_clk);              // skips a stale ack from the last transfer
      while (!ack && n < 4)
      begin
         @(negedge z80_clk);
         n++;
      end
      if (!ack)
      begin
         $display("no acknowledge from port %02h within 4 cycles", adr);
         $display("Test failed");
         $fatal(1, "bus hung");
      end
      else
      begin
         rdat   = dat_o;               // valid with ack
         wb.cyc = 1'b0;
         wb.stb = 1'b0;
         wb.we  = 1'b0;
      end
   endtask

   task automatic wb_write(input logic [7:0] adr, input logic [7:0] dat);
      logic [7:0] unused_rd;
      bus_xfer(adr, 1'b1, dat, unused_rd);
   endtask

   task automatic wb_read(input logic [7:0] adr, output logic [7:0] dat);
      bus_xfer(adr, 1'b0, 8'h00, dat);
   endtask

   task automatic reset_state();
      logic [7:0] d;
      check("reset ack", 0, ack);      // still in reset here
      check("reset int_n", 1, int_n);
      check("reset orch_l", 0, orch_l);
      check("reset orch_r", 0, orch_r);
      z80_rst_n = 1'b1;
      @(negedge z80_clk);
      wb_read(`T4IO_HIRES_BASE + 0, d);
      check("reset x", 8'h00, d);
      wb_read(`T4IO_HIRES_BASE + 1, d);
      check("reset y", 8'h00, d);
      wb_read(`T4IO_HIRES_BASE + 3, d);
      check("reset options", 8'h00, d);
      wb_read(`T4IO_INT_PORT, d);
      check("reset status", 8'hff, d);
   endtask

   task automatic hires_increment();
      t4io_dev_pkg::hires_opt_t o;
      logic [7:0]               copy [16];
      logic [7:0]               d;
      o = '1;
      o.x_wr_hold = 1'b0;              // x +1 on write, y held
      o.x_dec     = 1'b0;
      o.y_dec     = 1'b0;
      o.graphics_on = 1'b0;
      wb_write(`T4IO_HIRES_BASE + 3, o);
      wb_write(`T4IO_HIRES_BASE + 0, 8'h05);
      wb_write(`T4IO_HIRES_BASE + 1, 8'h09);
      for (int i = 0; i < 16; i++)
      begin
         copy[i] = $random(seed);
         wb_write(`T4IO_HIRES_BASE + 2, copy[i]);
      end
      wb_write(`T4IO_HIRES_BASE + 0, 8'h05);
      o = '1;
      o.x_rd_hold = 1'b0;              // now x +1 on read
      o.x_dec     = 1'b0;
      o.y_dec     = 1'b0;
      o.graphics_on = 1'b0;
      wb_write(`T4IO_HIRES_BASE + 3, o);
      for (int i = 0; i < 16; i++)
      begin
         wb_read(`T4IO_HIRES_BASE + 2, d);
         check("hires inc readback", copy[i], d);
      end
      wb_read(`T4IO_HIRES_BASE + 0, d);
      check("hires inc final x", 8'd21, d);
      wb_read(`T4IO_HIRES_BASE + 1, d);
      check("hires inc y held", 8'h09, d);
   endtask

   task automatic hires_decrement();
      t4io_dev_pkg::hires_opt_t o;
      logic [7:0]               copy [3];
      logic [7:0]               d;
      logic [7:0]               y_exp;
      o = '0;
      o.x_rd_hold   = 1'b1;            // x stays put
      o.x_wr_hold   = 1'b1;
      o.y_dec       = 1'b1;            // y steps down on both
      o.graphics_on = 1'b1;
      wb_write(`T4IO_HIRES_BASE + 3, o);
      check("hires graphics bit", 1, hires_graphics);
      wb_write(`T4IO_HIRES_BASE + 0, 8'h30);
      wb_write(`T4IO_HIRES_BASE + 1, 8'h01);
      y_exp = 8'h01;
      for (int i = 0; i < 3; i++)      // 01, 00, then wraps to ff
      begin
         copy[i] = $random(seed);
         wb_write(`T4IO_HIRES_BASE + 2, copy[i]);
         y_exp = y_exp - 8'd1;
         wb_read(`T4IO_HIRES_BASE + 1, d);
         check("hires dec y after write", y_exp, d);
      end
      wb_write(`T4IO_HIRES_BASE + 1, 8'h01);
      y_exp = 8'h01;
      for (int i = 0; i < 3; i++)
      begin
         wb_read(`T4IO_HIRES_BASE + 2, d);
         check("hires dec readback", copy[i], d);
         y_exp = y_exp - 8'd1;
         wb_read(`T4IO_HIRES_BASE + 1, d);
         check("hires dec y after read", y_exp, d);
      end
      wb_read(`T4IO_HIRES_BASE + 0, d);
      check("hires dec x held", 8'h30, d);
      x_last   = 8'h30;
      y_last   = y_exp;
      opt_last = o;
   endtask

   task automatic orch_duty();
      logic [7:0] vals [4];
      logic [7:0] val_r;               // right channel sample
      int         cnt_l;
      int         cnt_r;
      vals = '{8'h80, 8'h00, 8'h40, 8'hff};
      foreach (vals[i])
      begin
         val_r = ~vals[i];             // right gets a different sample
         wb_write(`T4IO_ORCH_L, vals[i]);
         wb_write(`T4IO_ORCH_R, val_r);
         repeat (4) @(negedge z80_clk);
         cnt_l = 0;
         cnt_r = 0;
         repeat (256)
         begin
            @(negedge z80_clk);
            cnt_l += orch_l;
            cnt_r += orch_r;
         end
         check("orch left duty", vals[i] ^ 8'h80, cnt_l);   // signed to offset
         check("orch right duty", val_r ^ 8'h80, cnt_r);
      end
   endtask

   task automatic rtc_interrupt();
      logic [7:0] d;
      wb_write(`T4IO_INT_PORT, 8'h00);
      rtc_tick = 1'b1;
      repeat (2) @(negedge z80_clk);
      rtc_tick = 1'b0;
      repeat (6)
      begin
         @(negedge z80_clk);
         check("rtc masked int_n", 1, int_n);
      end
      wb_read(`T4IO_INT_PORT, d);
      check("rtc status pending", 8'hfb, d);   // bit 2 low
      wb_write(`T4IO_INT_PORT, 8'h04);
      check("rtc unmasked int_n", 0, int_n);
      wb_read(`T4IO_RTC_PORT, d);
      check("rtc clear port data", 8'h00, d);
      check("rtc cleared int_n", 1, int_n);
      wb_read(`T4IO_INT_PORT, d);
      check("rtc status cleared", 8'hff, d);
   endtask

   task automatic undecoded_ports();
      logic [7:0] d;
      wb_read(8'h10, d);
      check("idle read 10", `T4IO_IDLE_DATA, d);
      wb_read(`T4IO_ORCH_L, d);        // write-only port
      check("idle read 75", `T4IO_IDLE_DATA, d);
      wb_read(8'hdf, d);
      check("idle read df", `T4IO_IDLE_DATA, d);
      wb_write(8'h10, $random(seed));  // must still be acked
      wb_write(8'hdf, $random(seed));
      wb_read(`T4IO_HIRES_BASE + 0, d);
      check("idle kept x", x_last, d);
      wb_read(`T4IO_HIRES_BASE + 1, d);
      check("idle kept y", y_last, d);
      wb_read(`T4IO_HIRES_BASE + 3, d);
      check("idle kept options", opt_last, d);
      wb_read(`T4IO_INT_PORT, d);
      check("idle kept status", 8'hff, d);
      check("idle kept int_n", 1, int_n);
   endtask

   initial
   begin
      seed      = 7;
      cycles    = 0;
      z80_clk   = 1'b0;
      z80_rst_n = 1'b0;
      wb        = '0;
      rtc_tick  = 1'b0;
      repeat (5) @(negedge z80_clk);   // reset held 5 cycles
      reset_state();
      hires_increment();
      hires_decrement();
      orch_duty();
      rtc_interrupt();
      undecoded_ports();
      $display("Test passed");
      $finish;
   end

endmodule

// File: t4io_top.sv
`include "t4io_defines.svh"

module t4io_top (
   input  logic                    z80_clk,
   input  logic                    z80_rst_n,
   input  t4io_bus_pkg::wb_req_t   wb,
   input  logic                    rtc_tick,    // async, from outside
   output logic                    ack,
   output logic [`T4IO_DATA_W-1:0] dat_o,
   output logic                    int_n,
   output logic                    orch_l,
   output logic                    orch_r,
   output logic                    hires_graphics
);

   t4io_bus_pkg::io_cmd_t   cmd;           // shared by all devices
   logic [`T4IO_DATA_W-1:0] hires_rdata;
   logic [`T4IO_DATA_W-1:0] int_rdata;

   t4io_port_decode u_decode (
      .z80_clk     (z80_clk),
      .z80_rst_n   (z80_rst_n),
      .wb          (wb),
      .ack         (ack),
      .dat_o       (dat_o),
      .cmd         (cmd),
      .hires_rdata (hires_rdata),
      .int_rdata   (int_rdata)
   );

   t4io_hires u_hires (
      .z80_clk     (z80_clk),
      .z80_rst_n   (z80_rst_n),
      .cmd         (cmd),
      .rdata       (hires_rdata),
      .graphics_on (hires_graphics)
   );

   t4io_orch90 u_orch90 (
      .z80_clk     (z80_clk),
      .z80_rst_n   (z80_rst_n),
      .cmd         (cmd),
      .orch_l      (orch_l),
      .orch_r      (orch_r)
   );

   t4io_int_ctrl u_int (
      .z80_clk     (z80_clk),
      .z80_rst_n   (z80_rst_n),
      .cmd         (cmd),
      .rtc_tick    (rtc_tick),
      .rdata       (int_rdata),
      .int_n       (int_n)
   );

endmodule

// File: t4io_int_ctrl.sv
`include "t4io_defines.svh"

module t4io_int_ctrl (
   input  logic                    z80_clk,
   input  logic                    z80_rst_n,
   input  t4io_bus_pkg::io_cmd_t   cmd,
   input  logic                    rtc_tick,
   output logic [`T4IO_DATA_W-1:0] rdata,
   output logic                    int_n
);

   logic [`T4IO_DATA_W-1:0] mask;       // 1 enables a source
   logic [1:0]              tick_sync;  // async tick, two flops
   logic                    tick_dly;   // for edge detect
   logic                    tick_rise;
   logic                    rtc_int;
   logic                    rtc_clr;
   logic [`T4IO_DATA_W-1:0] src;        // active high sources

   assign tick_rise = tick_sync[1] & ~tick_dly;
   assign rtc_clr   = cmd.rd & cmd.sel.rtc_clr;

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         mask      <= '0;
         tick_sync <= '0;
         tick_dly  <= 1'b0;
         rtc_int   <= 1'b0;
      end
      else
      begin
         if (cmd.wr & cmd.sel.int_mask)
            mask <= cmd.wdata;
         tick_sync <= {tick_sync[0], rtc_tick};
         tick_dly  <= tick_sync[1];
         if (tick_rise)
            rtc_int <= 1'b1;         // new tick beats a clear
         else if (rtc_clr)
            rtc_int <= 1'b0;
      end
   end

   always_comb
   begin
      src = '0;
      src[t4io_dev_pkg::INT_RTC_BIT] = rtc_int;
   end

   assign rdata = ~src;              // status reads 0 for active
   assign int_n = ~|(src & mask);

   // nothing reaches the host with every source masked
   a_mask_off: assert property (@(posedge z80_clk) disable iff (!z80_rst_n)
      (mask == '0) |-> int_n);

endmodule

// File: t4io_orch90.sv
`include "t4io_defines.svh"

module t4io_orch90 (
   input  logic                  z80_clk,
   input  logic                  z80_rst_n,
   input  t4io_bus_pkg::io_cmd_t cmd,
   output logic                  orch_l,
   output logic                  orch_r
);

   // index 0 left, 1 right
   logic [1:0]                   ld;
   logic [1:0][`T4IO_DATA_W-1:0] sample;   // signed samples as written
   logic [1:0][`T4IO_DATA_W:0]   acc;      // carry in the top bit

   assign ld[0] = cmd.wr & cmd.sel.orch_l;
   assign ld[1] = cmd.wr & cmd.sel.orch_r;

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         sample <= '0;
         acc    <= '0;
      end
      else
      begin
         for (int i = 0; i < 2; i++)
         begin
            if (ld[i])
               sample[i] <= cmd.wdata;
            // first order pdm, offset binary input
            acc[i] <= {1'b0, acc[i][`T4IO_DATA_W-1:0]}
                      + {1'b0, ~sample[i][`T4IO_DATA_W-1], sample[i][`T4IO_DATA_W-2:0]};
         end
      end
   end

   assign orch_l = acc[0][`T4IO_DATA_W];  // carry out is the pdm bit
   assign orch_r = acc[1][`T4IO_DATA_W];

endmodule

// File: t4io_hires.sv
`include "t4io_defines.svh"

module t4io_hires (
   input  logic                    z80_clk,
   input  logic                    z80_rst_n,
   input  t4io_bus_pkg::io_cmd_t   cmd,
   output logic [`T4IO_DATA_W-1:0] rdata,
   output logic                    graphics_on
);

   logic [`T4IO_DATA_W-1:0]  x;
   logic [`T4IO_DATA_W-1:0]  y;
   t4io_dev_pkg::hires_opt_t opt;
   t4io_dev_pkg::hires_sub_e sub;

   logic [`T4IO_DATA_W-1:0]  mem [`T4IO_HIRES_DEPTH];   // pixel memory, 32 KiB
   logic [`T4IO_HIRES_AW-1:0] addr;

   logic                     data_acc;   // data port pulse
   logic                     x_step;
   logic                     y_step;
   logic [`T4IO_DATA_W-1:0]  x_delta;
   logic [`T4IO_DATA_W-1:0]  y_delta;

   assign sub  = t4io_dev_pkg::hires_sub_e'(cmd.sub);
   assign addr = {x[6:0], y};                     // column over row, old x/y
   assign data_acc = cmd.sel.hires & (sub == t4io_dev_pkg::hires_data);

   // post-modify enables, read and write held separately
   assign x_step = data_acc & ((cmd.rd & ~opt.x_rd_hold) | (cmd.wr & ~opt.x_wr_hold));
   assign y_step = data_acc & ((cmd.rd & ~opt.y_rd_hold) | (cmd.wr & ~opt.y_wr_hold));
   assign x_delta = opt.x_dec ? 8'hff : 8'h01;    // -1 or +1
   assign y_delta = opt.y_dec ? 8'hff : 8'h01;

   assign graphics_on = opt.graphics_on;

   // pixel store, at the address held before the step
   always_ff @(posedge z80_clk)
   begin
      if (data_acc & cmd.wr)
         mem[addr] <= cmd.wdata;
   end

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         x   <= '0;
         y   <= '0;
         opt <= '0;
      end
      else if (cmd.sel.hires)
      begin
         case (sub)
            t4io_dev_pkg::hires_x:
               if (cmd.wr)
                  x <= cmd.wdata;
            t4io_dev_pkg::hires_y:
               if (cmd.wr)
                  y <= cmd.wdata;
            t4io_dev_pkg::hires_data:
            begin
               if (x_step)
                  x <= x + x_delta;      // wraps at 8 bits
               if (y_step)
                  y <= y + y_delta;
            end
            default:
               if (cmd.wr)
                  opt <= t4io_dev_pkg::hires_opt_t'(cmd.wdata);
         endcase
      end
   end

   // readback, data port returns the byte before the step
   always_comb
   begin
      case (sub)
         t4io_dev_pkg::hires_x:    rdata = x;
         t4io_dev_pkg::hires_y:    rdata = y;
         t4io_dev_pkg::hires_data: rdata = mem[addr];
         default:                  rdata = opt;
      endcase
   end

   // decoder never issues a read and a write in one transfer
   a_rd_wr_excl: assert property (@(posedge z80_clk) disable iff (!z80_rst_n)
      !(cmd.rd && cmd.wr));

endmodule

// File: t4io_port_decode.sv
`include "t4io_defines.svh"

module t4io_port_decode (
   input  logic                    z80_clk,
   input  logic                    z80_rst_n,
   input  t4io_bus_pkg::wb_req_t   wb,
   output logic                    ack,
   output logic [`T4IO_DATA_W-1:0] dat_o,
   output t4io_bus_pkg::io_cmd_t   cmd,
   input  logic [`T4IO_DATA_W-1:0] hires_rdata,
   input  logic [`T4IO_DATA_W-1:0] int_rdata
);

   logic                    req;       // new transfer seen this cycle
   t4io_bus_pkg::dev_sel_t  sel;
   logic [`T4IO_DATA_W-1:0] rd_word;

   // ack low masks the strobe still held during the ack cycle
   assign req = wb.cyc & wb.stb & ~ack;

   // port decode, address only
   always_comb
   begin
      sel          = '0;
      sel.hires    = ({wb.adr[`T4IO_PORT_W-1:2], 2'b00} == `T4IO_HIRES_BASE);
      sel.orch_l   = (wb.adr == `T4IO_ORCH_L);
      sel.orch_r   = (wb.adr == `T4IO_ORCH_R);
      sel.int_mask = (wb.adr == `T4IO_INT_PORT);
      sel.rtc_clr  = (wb.adr == `T4IO_RTC_PORT);
   end

   // command pulses land on the edge that raises ack
   always_comb
   begin
      cmd       = '0;
      cmd.sel   = sel;
      cmd.sub   = wb.adr[1:0];
      cmd.rd    = req & ~wb.we;
      cmd.wr    = req & wb.we;
      cmd.wdata = wb.dat;
   end

   // read word select
   // orchestra ports are write-only and fall through to idle
   always_comb
   begin
      if (sel.hires)
         rd_word = hires_rdata;
      else if (sel.int_mask)
         rd_word = int_rdata;        // status word
      else if (sel.rtc_clr)
         rd_word = '0;
      else
         rd_word = `T4IO_IDLE_DATA;
   end

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         ack   <= 1'b0;
         dat_o <= '0;
      end
      else
      begin
         ack <= req;                 // single cycle, never stalls
         if (cmd.rd)
            dat_o <= rd_word;        // valid alongside ack
      end
   end

   // held strobe must not produce a second ack
   a_ack_single: assert property (@(posedge z80_clk) disable iff (!z80_rst_n)
      ack |=> !ack);

   // ack answers a strobe sampled on the previous edge
   a_ack_after_stb: assert property (@(posedge z80_clk) disable iff (!z80_rst_n)
      $rose(ack) |-> $past(wb.cyc & wb.stb));

endmodule

// File: t4io_dev_pkg.sv
package t4io_dev_pkg;

   // hi-res options register, port 83
   // hold bits are active high, 0 lets x/y step after a data access
   typedef struct packed {
      logic y_wr_hold;     // bit 7
      logic x_wr_hold;
      logic y_rd_hold;
      logic x_rd_hold;
      logic y_dec;         // 1 steps y down
      logic x_dec;         // 1 steps x down
      logic unused;
      logic graphics_on;   // bit 0, kept as a plain register bit
   } hires_opt_t;

   // hi-res sub-registers by low address bits
   typedef enum logic [1:0] {
      hires_x    = 2'd0,
      hires_y    = 2'd1,
      hires_data = 2'd2,
      hires_opt  = 2'd3
   } hires_sub_e;

   // status bit of the rtc interrupt
   // status reads active low, mask is active high
   parameter int INT_RTC_BIT = 2;

endpackage

// File: t4io_bus_pkg.sv
`include "t4io_defines.svh"

package t4io_bus_pkg;

   // wishbone classic request from the host
   typedef struct packed {
      logic [`T4IO_PORT_W-1:0] adr;    // port number
      logic [`T4IO_DATA_W-1:0] dat;    // write data
      logic                    we;
      logic                    cyc;
      logic                    stb;
   } wb_req_t;

   // one-hot, at most one bit set for any port
   typedef struct packed {
      logic hires;      // 80-83
      logic orch_l;     // 75
      logic orch_r;     // 79
      logic int_mask;   // e0, mask write / status read
      logic rtc_clr;    // ec
   } dev_sel_t;

   // decoded transfer, same word fans out to every device
   typedef struct packed {
      dev_sel_t                sel;
      logic [1:0]              sub;     // sub-register within a port group
      logic                    rd;      // one cycle per read transfer
      logic                    wr;      // one cycle per write transfer
      logic [`T4IO_DATA_W-1:0] wdata;
   } io_cmd_t;

endpackage

// File: t4io_defines.svh
`ifndef T4IO_DEFINES_SVH
`define T4IO_DEFINES_SVH

// bus widths
`define T4IO_PORT_W       8                  // z80 i/o port address
`define T4IO_DATA_W       8

// hi-res graphics board, four ports from here
// low two address bits pick x, y, data or options
`define T4IO_HIRES_BASE   8'h80

// orchestra-90 left and right channels
`define T4IO_ORCH_L       8'h75
`define T4IO_ORCH_R       8'h79

// interrupt mask on write, status on read
`define T4IO_INT_PORT     8'he0
// read here to drop the rtc interrupt
`define T4IO_RTC_PORT     8'hec

// undecoded ports read back as a floating bus
`define T4IO_IDLE_DATA    8'hff

// pixel memory, 7 bits of x over 8 bits of y
`define T4IO_HIRES_AW     15
`define T4IO_HIRES_DEPTH  (1 << `T4IO_HIRES_AW)

`endif
